// File: include/sched_defs.svh
`ifndef SCHED_DEFS_SVH
`define SCHED_DEFS_SVH

// Scheduler window, also the dependency matrix size
`define SCHED_ENTRIES 8

// Architectural register count
`define SCHED_REGS 8

// Register file and result width
`define SCHED_DATA_W 16

// Sequence number width, wraps after 256 accepts
`define SCHED_SEQ_W 8

`endif

// File: src/sched_pkg.sv
`include "sched_defs.svh"

package sched_pkg;

    // Top bit set marks the immediate form
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_XOR  = 4'h3,
        OP_ADDI = 4'h8,
        OP_LUI  = 4'h9                              // imm into bits 15:10
    } opcode_e;

    typedef struct packed {
        opcode_e                           opcode;
        logic [$clog2(`SCHED_REGS)-1:0]    rd;
        logic [$clog2(`SCHED_REGS)-1:0]    rs1;
        logic [$clog2(`SCHED_REGS)-1:0]    rs2;
        logic [2:0]                        spare;  // Ignored by decode
    } insn_reg_t;

    typedef struct packed {
        opcode_e                           opcode;
        logic [$clog2(`SCHED_REGS)-1:0]    rd;
        logic [$clog2(`SCHED_REGS)-1:0]    rs1;
        logic [5:0]                        imm;
    } insn_imm_t;

    // One 16-bit word, two readings picked by opcode[3]
    typedef union packed {
        insn_reg_t r;
        insn_imm_t i;
    } insn_u;

    typedef struct packed {
        opcode_e                           opcode;
        logic [$clog2(`SCHED_REGS)-1:0]    rd;
        logic [$clog2(`SCHED_REGS)-1:0]    rs1;
        logic [$clog2(`SCHED_REGS)-1:0]    rs2;    // Zero for immediate form
        logic [`SCHED_DATA_W-1:0]          imm;    // Zero-extended
        logic                              is_imm;
        logic [`SCHED_SEQ_W-1:0]           seq;
    } entry_t;

    typedef struct packed {
        logic [`SCHED_SEQ_W-1:0]           seq;
        logic [$clog2(`SCHED_REGS)-1:0]    rd;
        logic [`SCHED_DATA_W-1:0]          value;
    } result_t;

endpackage

// File: src/insn_decode.sv
`timescale 1ns/1ps
`include "sched_defs.svh"

module insn_decode (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_req,
    input  sched_pkg::insn_u                  in_insn,
    input  logic                              issue_en,
    input  logic [$clog2(`SCHED_ENTRIES)-1:0] issue_tag,
    input  logic                              wb_en,
    input  logic [$clog2(`SCHED_ENTRIES)-1:0] wb_tag,
    output logic                              in_ack,
    output logic                              w_en,
    output logic [$clog2(`SCHED_ENTRIES)-1:0] w_row_index,
    output logic [`SCHED_ENTRIES-1:0]         set_lines,
    output sched_pkg::entry_t                 payload
);
    localparam int TAG_W = $clog2(`SCHED_ENTRIES);
    localparam int REG_W = $clog2(`SCHED_REGS);

    logic [`SCHED_ENTRIES-1:0] busy;                   // Held from accept until writeback
    logic [`SCHED_REGS-1:0]    prod_valid;             // Register has an in-flight writer
    logic [TAG_W-1:0]          prod_tag [`SCHED_REGS]; // Entry of that writer
    logic [`SCHED_ENTRIES-1:0] readers [`SCHED_REGS];  // Entries that have not read it yet
    logic [`SCHED_SEQ_W-1:0]   seq_q;
    logic                      is_imm;
    logic                      use_rs1;
    logic                      use_rs2;
    logic [REG_W-1:0]          rd;
    logic [REG_W-1:0]          rs1;
    logic [REG_W-1:0]          rs2;
    logic                      entry_free;
    logic [TAG_W-1:0]          alloc_tag;
    logic [`SCHED_ENTRIES-1:0] alloc_mask;
    logic [`SCHED_ENTRIES-1:0] issue_mask;
    logic [`SCHED_ENTRIES-1:0] wb_mask;
    logic [`SCHED_ENTRIES-1:0] raw1_mask;
    logic [`SCHED_ENTRIES-1:0] raw2_mask;
    logic [`SCHED_ENTRIES-1:0] waw_mask;
    logic [`SCHED_ENTRIES-1:0] war_mask;
    logic [`SCHED_REGS-1:0]    new_reads;              // Registers the new entry reads

    always_comb begin
        is_imm  = in_insn.r.opcode[3];                 // Selects the union view
        use_rs1 = in_insn.r.opcode != sched_pkg::OP_LUI;
        use_rs2 = !is_imm;
        rd      = in_insn.r.rd;
        rs1     = in_insn.r.rs1;
        rs2     = is_imm ? '0 : in_insn.r.rs2;
        alloc_tag  = '0;
        entry_free = 1'b0;
        for (int e = `SCHED_ENTRIES - 1; e >= 0; e--) begin
            if (!busy[e]) begin                        // Lowest free index wins
                alloc_tag  = TAG_W'(e);
                entry_free = 1'b1;
            end
        end
        w_en        = in_req && !in_ack && entry_free;
        w_row_index = alloc_tag;
        alloc_mask  = `SCHED_ENTRIES'(1) << alloc_tag;
        issue_mask  = issue_en ? (`SCHED_ENTRIES'(1) << issue_tag) : '0;
        wb_mask     = wb_en ? (`SCHED_ENTRIES'(1) << wb_tag) : '0;
        raw1_mask = (use_rs1 && prod_valid[rs1]) ? (`SCHED_ENTRIES'(1) << prod_tag[rs1]) : '0;
        raw2_mask = (use_rs2 && prod_valid[rs2]) ? (`SCHED_ENTRIES'(1) << prod_tag[rs2]) : '0;
        waw_mask  = prod_valid[rd] ? (`SCHED_ENTRIES'(1) << prod_tag[rd]) : '0;
        war_mask  = readers[rd] & ~issue_mask;         // Issued readers already have operands
        set_lines = (raw1_mask | raw2_mask | waw_mask | war_mask) & ~wb_mask; // Keep wakeup
        for (int r = 0; r < `SCHED_REGS; r++) begin
            new_reads[r] = w_en && ((use_rs1 && rs1 == REG_W'(r)) ||
                                    (use_rs2 && rs2 == REG_W'(r)));
        end
        payload.opcode = in_insn.r.opcode;
        payload.rd     = rd;
        payload.rs1    = rs1;
        payload.rs2    = rs2;
        payload.imm    = is_imm ? `SCHED_DATA_W'(in_insn.i.imm) : '0;
        payload.is_imm = is_imm;
        payload.seq    = seq_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ack     <= 1'b0;
            busy       <= '0;
            prod_valid <= '0;
            seq_q      <= '0;
            for (int r = 0; r < `SCHED_REGS; r++) begin
                prod_tag[r] <= '0;
                readers[r]  <= '0;
            end
        end else begin
            if (w_en) begin
                in_ack <= 1'b1;
                seq_q  <= seq_q + 1'b1;
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;                        // Four-phase return to idle
            end
            busy <= (busy & ~wb_mask) | (w_en ? alloc_mask : '0);
            for (int r = 0; r < `SCHED_REGS; r++) begin
                readers[r] <= (readers[r] & ~issue_mask) | (new_reads[r] ? alloc_mask : '0);
                if (w_en && rd == REG_W'(r)) begin     // New entry becomes the producer
                    prod_valid[r] <= 1'b1;
                    prod_tag[r]   <= alloc_tag;
                end else if (wb_en && prod_tag[r] == wb_tag) begin
                    prod_valid[r] <= 1'b0;             // Value now in the register file
                end
            end
        end
    end

endmodule

// File: src/dependency_matrix.sv
`timescale 1ns/1ps
`include "sched_defs.svh"

module dependency_matrix #(
    parameter int NUM_ROWS = `SCHED_ENTRIES           // Rows and columns are both entries
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        w_en,           // New instruction into a row
    input  logic [$clog2(NUM_ROWS)-1:0] w_row_index,
    input  logic [NUM_ROWS-1:0]         set_lines,      // Producers the new row waits on
    input  logic                        clear_en,       // Producer wrote back
    input  logic [$clog2(NUM_ROWS)-1:0] clear_col,
    input  logic                        free_en,        // Row selected for execution
    input  logic [$clog2(NUM_ROWS)-1:0] free_row_index,
    output logic [NUM_ROWS-1:0]         ready_vector
);
    logic [NUM_ROWS-1:0] dep_bits [NUM_ROWS];           // Row waits on column when set
    logic [NUM_ROWS-1:0] row_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            row_valid <= '0;
            for (int i = 0; i < NUM_ROWS; i++) begin
                dep_bits[i] <= '0;
            end
        end else begin
            if (clear_en) begin
                for (int i = 0; i < NUM_ROWS; i++) begin
                    dep_bits[i][clear_col] <= 1'b0;     // Wake every consumer
                end
            end
            if (w_en) begin                             // Overrides the clear on this row
                row_valid[w_row_index] <= 1'b1;
                dep_bits[w_row_index]  <= set_lines;
            end
            if (free_en) begin
                row_valid[free_row_index] <= 1'b0;
                dep_bits[free_row_index]  <= '0;
            end
        end
    end

    // Ready once valid and every producer has written back
    always_comb begin
        for (int i = 0; i < NUM_ROWS; i++) begin
            ready_vector[i] = row_valid[i] && (dep_bits[i] == '0);
        end
    end

endmodule

// File: src/issue_execute.sv
`timescale 1ns/1ps
`include "sched_defs.svh"

module issue_execute (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              w_en,
    input  logic [$clog2(`SCHED_ENTRIES)-1:0] w_row_index,
    input  sched_pkg::entry_t                 payload,
    input  logic [`SCHED_ENTRIES-1:0]         ready_vector,
    input  logic                              wb_accept,
    input  logic [`SCHED_DATA_W-1:0]          rf_rdata1,
    input  logic [`SCHED_DATA_W-1:0]          rf_rdata2,
    output logic                              free_en,
    output logic [$clog2(`SCHED_ENTRIES)-1:0] free_row_index,
    output logic                              issue_en,
    output logic [$clog2(`SCHED_ENTRIES)-1:0] issue_tag,
    output logic [$clog2(`SCHED_REGS)-1:0]    rf_raddr1,
    output logic [$clog2(`SCHED_REGS)-1:0]    rf_raddr2,
    output logic                              ex_valid,
    output sched_pkg::result_t                ex_result,
    output logic [$clog2(`SCHED_ENTRIES)-1:0] ex_tag
);
    localparam int TAG_W = $clog2(`SCHED_ENTRIES);

    sched_pkg::entry_t        pay_mem [`SCHED_ENTRIES];  // Decoded fields per entry
    sched_pkg::entry_t        sel_pay;
    logic [TAG_W-1:0]         sel_tag;
    logic                     sel_any;
    logic                     advance;
    logic                     issue;
    logic [`SCHED_DATA_W-1:0] opnd_b;
    logic [`SCHED_DATA_W-1:0] alu_out;

    always_ff @(posedge clk) begin
        if (w_en) begin
            pay_mem[w_row_index] <= payload;
        end
    end

    always_comb begin
        sel_tag = '0;
        sel_any = 1'b0;
        for (int e = `SCHED_ENTRIES - 1; e >= 0; e--) begin
            if (ready_vector[e]) begin                   // Lowest ready index
                sel_tag = TAG_W'(e);
                sel_any = 1'b1;
            end
        end
        advance = !ex_valid || wb_accept;                // Stage empty or draining now
        issue   = advance && sel_any;
        sel_pay = pay_mem[sel_tag];
        rf_raddr1 = sel_pay.rs1;
        rf_raddr2 = sel_pay.rs2;
        opnd_b    = sel_pay.is_imm ? sel_pay.imm : rf_rdata2;
        case (sel_pay.opcode)
            sched_pkg::OP_ADD,
            sched_pkg::OP_ADDI: alu_out = rf_rdata1 + opnd_b;
            sched_pkg::OP_SUB:  alu_out = rf_rdata1 - opnd_b;
            sched_pkg::OP_AND:  alu_out = rf_rdata1 & opnd_b;
            sched_pkg::OP_XOR:  alu_out = rf_rdata1 ^ opnd_b;
            sched_pkg::OP_LUI:  alu_out = sel_pay.imm << (`SCHED_DATA_W - 6); // Top 6 bits
            default:            alu_out = '0;
        endcase
        free_en        = issue;                          // Row leaves the matrix on issue
        free_row_index = sel_tag;
        issue_en       = issue;
        issue_tag      = sel_tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (issue) begin
            ex_valid <= 1'b1;
        end else if (wb_accept) begin
            ex_valid <= 1'b0;
        end
    end

    // Result payload, held while writeback stalls
    always_ff @(posedge clk) begin
        if (issue) begin
            ex_result.seq   <= sel_pay.seq;
            ex_result.rd    <= sel_pay.rd;
            ex_result.value <= alu_out;
            ex_tag          <= sel_tag;                  // Entry to wake and free
        end
    end

endmodule

// File: src/result_writeback.sv
`timescale 1ns/1ps
`include "sched_defs.svh"

module result_writeback (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              ex_valid,
    input  sched_pkg::result_t                ex_result,
    input  logic [$clog2(`SCHED_ENTRIES)-1:0] ex_tag,
    input  logic [$clog2(`SCHED_REGS)-1:0]    rf_raddr1,
    input  logic [$clog2(`SCHED_REGS)-1:0]    rf_raddr2,
    input  logic                              out_ack,
    output logic                              wb_accept,
    output logic                              wb_en,
    output logic [$clog2(`SCHED_ENTRIES)-1:0] wb_tag,
    output logic [`SCHED_DATA_W-1:0]          rf_rdata1,
    output logic [`SCHED_DATA_W-1:0]          rf_rdata2,
    output logic                              out_req,
    output sched_pkg::result_t                out_result
);
    logic [`SCHED_DATA_W-1:0] rf [`SCHED_REGS];          // Architectural registers
    logic                     buf_full;                  // Output buffer owns a result

    assign wb_accept = ex_valid && !buf_full;
    assign wb_en     = wb_accept;                        // One wakeup per accepted result
    assign wb_tag    = ex_tag;
    assign rf_rdata1 = rf[rf_raddr1];                    // Combinational read ports
    assign rf_rdata2 = rf[rf_raddr2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `SCHED_REGS; r++) begin
                rf[r] <= '0;
            end
        end else if (wb_accept) begin
            rf[ex_result.rd] <= ex_result.value;         // Same edge as the column clear
        end
    end

    // Output four-phase handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_full <= 1'b0;
            out_req  <= 1'b0;
        end else if (wb_accept) begin
            buf_full <= 1'b1;
            out_req  <= 1'b1;
        end else if (out_req && out_ack) begin
            out_req <= 1'b0;
        end else if (buf_full && !out_req && !out_ack) begin
            buf_full <= 1'b0;                            // Sink back to idle
        end
    end

    always_ff @(posedge clk) begin
        if (wb_accept) begin
            out_result <= ex_result;
        end
    end

endmodule

// File: src/sched_top.sv
`timescale 1ns/1ps
`include "sched_defs.svh"

module sched_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_req,
    input  sched_pkg::insn_u   in_insn,
    input  logic               out_ack,
    output logic               in_ack,
    output logic               out_req,
    output sched_pkg::result_t out_result
);
    localparam int TAG_W = $clog2(`SCHED_ENTRIES);
    localparam int REG_W = $clog2(`SCHED_REGS);

    logic                      w_en;
    logic [TAG_W-1:0]          w_row_index;
    logic [`SCHED_ENTRIES-1:0] set_lines;
    sched_pkg::entry_t         payload;
    logic [`SCHED_ENTRIES-1:0] ready_vector;
    logic                      free_en;
    logic [TAG_W-1:0]          free_row_index;
    logic                      issue_en;
    logic [TAG_W-1:0]          issue_tag;
    logic [REG_W-1:0]          rf_raddr1;
    logic [REG_W-1:0]          rf_raddr2;
    logic [`SCHED_DATA_W-1:0]  rf_rdata1;
    logic [`SCHED_DATA_W-1:0]  rf_rdata2;
    logic                      ex_valid;
    sched_pkg::result_t        ex_result;
    logic [TAG_W-1:0]          ex_tag;
    logic                      wb_accept;
    logic                      wb_en;                    // Wakeup and free broadcast
    logic [TAG_W-1:0]          wb_tag;

    insn_decode i_decode (
        .clk, .rst, .in_req, .in_insn, .issue_en, .issue_tag, .wb_en, .wb_tag,
        .in_ack, .w_en, .w_row_index, .set_lines, .payload
    );

    dependency_matrix #(.NUM_ROWS(`SCHED_ENTRIES)) i_matrix (
        .clk, .rst, .w_en, .w_row_index, .set_lines,
        .clear_en (wb_en),                               // Writeback clears the column
        .clear_col(wb_tag),
        .free_en, .free_row_index, .ready_vector
    );

    issue_execute i_execute (
        .clk, .rst, .w_en, .w_row_index, .payload, .ready_vector, .wb_accept,
        .rf_rdata1, .rf_rdata2, .free_en, .free_row_index, .issue_en, .issue_tag,
        .rf_raddr1, .rf_raddr2, .ex_valid, .ex_result, .ex_tag
    );

    result_writeback i_writeback (
        .clk, .rst, .ex_valid, .ex_result, .ex_tag, .rf_raddr1, .rf_raddr2, .out_ack,
        .wb_accept, .wb_en, .wb_tag, .rf_rdata1, .rf_rdata2, .out_req, .out_result
    );

endmodule

// File: sim/tb_sched.sv
`timescale 1ns/1ps
`include "sched_defs.svh"

module tb_sched;
    localparam int CLK_PERIOD   = 8;
    localparam int NUM_ROWS     = 25;
    localparam int BURST_FIRST  = 13;                   // First row of the independent burst
    localparam int CYCLE_BUDGET = 40;                   // Watchdog cycles per row
    localparam int HOLD_CYCLES  = 80;                   // Output stall long enough to fill entries
    localparam int REG_W        = $clog2(`SCHED_REGS);

    typedef struct packed {
        sched_pkg::insn_u         insn;
        logic [REG_W-1:0]         rd;
        logic [`SCHED_DATA_W-1:0] value;                // Sequential program-order result
    } row_t;

    logic               clk;
    logic               rst;
    logic               in_req;
    sched_pkg::insn_u   in_insn;
    logic               in_ack;
    logic               out_req;
    sched_pkg::result_t out_result;
    logic               out_ack;

    row_t   rows [NUM_ROWS];
    string  row_name [NUM_ROWS];
    int     row_fill;
    int     seen [NUM_ROWS];                            // Arrivals per sequence number
    int     received;
    int     pass_count;
    int     fail_count;
    int     burst_stalls;                               // Accepts that waited on a free entry
    integer seed;

    sched_top i_dut (
        .clk, .rst, .in_req, .in_insn, .out_ack, .in_ack, .out_req, .out_result
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic sched_pkg::insn_u reg_form(input sched_pkg::opcode_e op,
                                                  input int rd, input int rs1, input int rs2);
        sched_pkg::insn_u u;
        u.r.opcode = op;
        u.r.rd     = REG_W'(rd);
        u.r.rs1    = REG_W'(rs1);
        u.r.rs2    = REG_W'(rs2);
        u.r.spare  = 3'b000;
        return u;
    endfunction

    function automatic sched_pkg::insn_u imm_form(input sched_pkg::opcode_e op,
                                                  input int rd, input int rs1, input int imm);
        sched_pkg::insn_u u;
        u.i.opcode = op;
        u.i.rd     = REG_W'(rd);
        u.i.rs1    = REG_W'(rs1);
        u.i.imm    = 6'(imm);
        return u;
    endfunction

    task automatic add_row(input string name, input sched_pkg::insn_u insn, input int rd,
                           input int value);
        row_name[row_fill]   = name;
        rows[row_fill].insn  = insn;
        rows[row_fill].rd    = REG_W'(rd);
        rows[row_fill].value = `SCHED_DATA_W'(value);
        row_fill++;
    endtask

    // Registers start at zero, values follow plain sequential execution
    task automatic fill_rows();
        int imm;
        row_fill = 0;
        add_row("addi_small",   imm_form(sched_pkg::OP_ADDI, 1, 0, 5),  1, 16'h0005);
        add_row("addi_zext",    imm_form(sched_pkg::OP_ADDI, 2, 0, 63), 2, 16'h003f);
        add_row("lui_mid",      imm_form(sched_pkg::OP_LUI,  3, 0, 45), 3, 16'hb400);
        add_row("lui_all_ones", imm_form(sched_pkg::OP_LUI,  4, 0, 63), 4, 16'hfc00);
        add_row("raw_add",      reg_form(sched_pkg::OP_ADD,  5, 1, 2),  5, 16'h0044);
        add_row("raw_sub",      reg_form(sched_pkg::OP_SUB,  5, 5, 3),  5, 16'h4c44);
        add_row("raw_and",      reg_form(sched_pkg::OP_AND,  6, 5, 4),  6, 16'h4c00);
        add_row("raw_xor",      reg_form(sched_pkg::OP_XOR,  7, 6, 1),  7, 16'h4c05);
        add_row("war_reader",   reg_form(sched_pkg::OP_ADD,  3, 1, 7),  3, 16'h4c0a);
        add_row("war_writer",   imm_form(sched_pkg::OP_ADDI, 1, 0, 9),  1, 16'h0009);
        add_row("waw_rewrite",  imm_form(sched_pkg::OP_ADDI, 3, 0, 1),  3, 16'h0001);
        add_row("waw_reader",   reg_form(sched_pkg::OP_ADD,  4, 3, 1),  4, 16'h000a);
        add_row("war_late_sub", reg_form(sched_pkg::OP_SUB,  5, 3, 1),  5, 16'hfff8);
        for (int k = 0; k < NUM_ROWS - BURST_FIRST; k++) begin
            imm = (k * 11 + 3) % 64;                    // LUI needs no source register
            add_row($sformatf("burst_lui_%0d", k), imm_form(sched_pkg::OP_LUI, k % 8, 0, imm),
                    k % 8, imm * 1024);                 // Immediate lands in bits 15:10
        end
    endtask

    task automatic check_result(input string name, input sched_pkg::result_t expected,
                                input sched_pkg::result_t actual);
        if (actual.rd === expected.rd && actual.value === expected.value) begin
            pass_count++;
            $display("[PASS]  %s: rd=%0d value=%h", name, actual.rd, actual.value);
        end else begin
            fail_count++;
            $display("[ERROR] %s: expected rd=%0d value=%h, actual rd=%0d value=%h",
                     name, expected.rd, expected.value, actual.rd, actual.value);
        end
    endtask

    task automatic check_idle(input string name, input logic expected, input logic actual);
        if (actual === expected) begin
            pass_count++;
            $display("[PASS]  %s: %b", name, actual);
        end else begin
            fail_count++;
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Four-phase input, sampled on the falling edge
    task automatic send_insn(input int idx);
        int wait_cycles;
        wait_cycles = 0;
        @(posedge clk);
        in_req  <= 1'b1;
        in_insn <= rows[idx].insn;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (in_ack !== 1'b1);
        if (idx >= BURST_FIRST && wait_cycles > 2) begin
            burst_stalls++;                             // Two samples is the unstalled case
        end
        @(posedge clk);
        in_req <= 1'b0;
        do begin
            @(negedge clk);
        end while (in_ack !== 1'b0);
    endtask

    initial begin : output_sink
        sched_pkg::result_t got;
        sched_pkg::result_t expected;
        int                 idx;
        int                 delay;
        forever begin
            do begin
                @(negedge clk);
            end while (out_req !== 1'b1);
            got = out_result;
            idx = int'(got.seq);                        // Sequence number is the row index
            if (idx >= NUM_ROWS) begin
                fail_count++;
                $display("A result came back with unknown sequence number %0d", idx);
            end else if (seen[idx] > 0) begin
                fail_count++;
                $display("Sequence number %0d (%s) came back a second time", idx, row_name[idx]);
            end else begin
                expected.seq   = got.seq;
                expected.rd    = rows[idx].rd;
                expected.value = rows[idx].value;
                check_result(row_name[idx], expected, got);
            end
            if (idx < NUM_ROWS) begin
                seen[idx]++;
            end
            received++;
            if (idx == BURST_FIRST) begin
                delay = HOLD_CYCLES;                    // Back-pressure until decode stalls
            end else begin
                delay = $unsigned($random(seed)) % 6;
            end
            repeat (delay) @(posedge clk);
            @(posedge clk);
            out_ack <= 1'b1;
            do begin
                @(negedge clk);
            end while (out_req !== 1'b0);
            @(posedge clk);
            out_ack <= 1'b0;
        end
    end

    initial begin : watchdog
        #(NUM_ROWS * CYCLE_BUDGET * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles with %0d of %0d results back",
                 NUM_ROWS * CYCLE_BUDGET, received, NUM_ROWS);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main_sequence
        seed         = 32'h30ba9e2c;
        rst          = 1'b1;
        in_req       = 1'b0;
        in_insn      = '0;
        out_ack      = 1'b0;
        received     = 0;
        pass_count   = 0;
        fail_count   = 0;
        burst_stalls = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            seen[i] = 0;
        end
        fill_rows();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle("reset_in_ack", 1'b0, in_ack);
        check_idle("reset_out_req", 1'b0, out_req);
        for (int i = 0; i < NUM_ROWS; i++) begin
            send_insn(i);
        end
        wait (received >= NUM_ROWS);
        repeat (4) @(posedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (seen[i] == 0) begin
                fail_count++;
                $display("Sequence number %0d (%s) never came back", i, row_name[i]);
            end
        end
        if (burst_stalls == 0) begin
            fail_count++;
            $display("in_ack never stalled during the burst, so the entries never filled");
        end
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
src/sched_pkg.sv
src/insn_decode.sv
src/dependency_matrix.sv
src/issue_execute.sv
src/result_writeback.sv
src/sched_top.sv
sim/tb_sched.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tb_sched
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
